// ==== bench/memory_system_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_system_tb;

    import soc_bus_pkg::*;
    import board_io_pkg::*;

    localparam int tb_ram_words = 1024;
    localparam int max_cycles   = 4000;
    localparam int rand_writes  = 40;

    // table operations
    localparam int op_write_b   = 0;
    localparam int op_read_a    = 1;
    localparam int op_read_b    = 2;
    localparam int op_set_in    = 3;    // addr picks the input
    localparam int op_read_disp = 4;    // expected is {color, char}
    localparam int op_check_out = 5;    // addr picks led1, led2, seg1, seg2

    localparam logic [23:0] sw_levels  = 24'hff3ca5;   // sw3, sw2, sw1
    localparam logic [4:0]  btn_levels = 5'b10110;     // bt5 down to bt1

    logic  clk;
    logic  rst_n;
    data_t addra, addrb, write_datab, sepc;
    logic  web;
    logic  [swch_width-1:0] switches1, switches2, switches3;
    logic  bt1, bt2, bt3, bt4, bt5;
    logic  [kbcode_width-1:0] kb_idx;
    logic  [vga_addr_width-1:0] vga_addr;
    data_t dataa, datab, seg1_out, seg2_out;
    logic  [led_width-1:0] led1_out, led2_out;
    cell_t char_out, color_out;

    int    op_q[$];
    data_t addr_q[$];
    data_t data_q[$];
    data_t exp_q[$];

    // copy of excp_rom.hex
    data_t rom_image [16] = '{
        32'h3c1affff, 32'h8f5bff28, 32'h00000000, 32'h277b0004,
        32'h409b7000, 32'h00000000, 32'h42000018, 32'h00000000,
        32'h3c08dead, 32'h3508beef, 32'had08ff2c, 32'h1000ffff,
        32'h00000000, 32'h0bf02400, 32'h24420001, 32'h00000000
    };

    data_t  model [tb_ram_words];
    data_t  rand_addr [rand_writes];
    integer seed;
    int     errors;
    int     checks;

    memory_system #(
        .ram_words (tb_ram_words)
    ) dut (
        .clka (clk), .clkb (clk), .rst_n (rst_n),
        .addra (addra), .addrb (addrb), .write_datab (write_datab), .sepc (sepc),
        .web (web), .switches1 (switches1), .switches2 (switches2),
        .switches3 (switches3), .bt1 (bt1), .bt2 (bt2), .bt3 (bt3), .bt4 (bt4),
        .bt5 (bt5), .kb_idx (kb_idx), .vga_addr (vga_addr), .dataa (dataa),
        .datab (datab), .seg1_out (seg1_out), .seg2_out (seg2_out),
        .led1_out (led1_out), .led2_out (led2_out), .char_out (char_out),
        .color_out (color_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog for the whole run
    initial begin
        for (int c = 0; c < max_cycles; c++) begin
            @(posedge clk);
        end
        $display("simulation timed out before the stimulus table finished");
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic data_t mmio_addr(input logic [7:0] off);
        return {24'hffffff, off};
    endfunction

    task automatic step_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
        end
    endtask

    task automatic add_entry(input int op, input data_t addr, input data_t data,
                             input data_t exp);
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        exp_q.push_back(exp);
    endtask

    task automatic check_value(input string name, input data_t act, input data_t exp);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED at %0t ns: %s expected %08h, actual %08h", $time, name, exp, act);
        end
    endtask

    task automatic set_board_input(input data_t sel, input data_t value);
        case (sel)
            0: switches1 = value[7:0];
            1: switches2 = value[7:0];
            2: switches3 = value[7:0];
            3: {bt5, bt4, bt3, bt2, bt1} = value[4:0];
            4: kb_idx = value[4:0];
            default: sepc = value;
        endcase
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic apply_entry(input int i);
        case (op_q[i])
            op_write_b: begin
                addrb = addr_q[i];
                write_datab = data_q[i];
                web = 1'b1;
                step_cycles(1);
                web = 1'b0;
            end
            op_read_a: begin
                addra = addr_q[i];
                step_cycles(read_latency);
                check_value("dataa", dataa, exp_q[i]);
            end
            op_read_b: begin
                addrb = addr_q[i];
                step_cycles(read_latency);
                check_value("datab", datab, exp_q[i]);
            end
            op_set_in: set_board_input(addr_q[i], data_q[i]);
            op_read_disp: begin
                vga_addr = addr_q[i][vga_addr_width-1:0];
                step_cycles(read_latency);
                check_value("char_out", data_t'(char_out), data_t'(exp_q[i][7:0]));
                check_value("color_out", data_t'(color_out), data_t'(exp_q[i][15:8]));
            end
            op_check_out: begin
                case (addr_q[i])
                    0: check_value("led1_out", data_t'(led1_out), exp_q[i]);
                    1: check_value("led2_out", data_t'(led2_out), exp_q[i]);
                    2: check_value("seg1_out", seg1_out, exp_q[i]);
                    default: check_value("seg2_out", seg2_out, exp_q[i]);
                endcase
            end
            default: begin
                errors++;
                $display("table entry %0d holds an unknown operation", i);
            end
        endcase
    endtask

    task automatic build_table();
        data_t a;
        data_t d;
        for (int k = 0; k < 4; k++) begin
            add_entry(op_check_out, k, 0, 0);       // outputs cleared by reset
        end
        add_entry(op_write_b, 32'h0000_0100, 32'hcafe_f00d, 0);
        add_entry(op_read_b, 32'h0000_0100, 0, 32'hcafe_f00d);
        add_entry(op_read_a, 32'h0000_0100, 0, 32'hcafe_f00d);
        for (int k = 0; k < 16; k++) begin
            add_entry(op_read_a, 32'h1c09_0000 + 4 * k, 0, rom_image[k]);
        end
        add_entry(op_read_a, 32'h1c09_0040, 0, 0);  // past the image
        add_entry(op_read_a, 32'h1c09_03fc, 0, 0);
        for (int k = 0; k < 3; k++) begin
            add_entry(op_set_in, k, data_t'(sw_levels[8*k +: 8]), 0);
            add_entry(op_read_b, mmio_addr(sw1_off + 8'(4 * k)), 0,
                      data_t'(sw_levels[8*k +: 8]));
        end
        add_entry(op_set_in, 3, data_t'(btn_levels), 0);
        for (int k = 0; k < 5; k++) begin
            add_entry(op_read_b, mmio_addr(btn_mid_off + 8'(4 * k)), 0,
                      data_t'(btn_levels[k]));
        end
        add_entry(op_set_in, 5, 32'hbfc0_0180, 0);
        add_entry(op_read_b, mmio_addr(sepc_off), 0, 32'hbfc0_0180);
        add_entry(op_set_in, 4, 32'h1b, 0);         // key 11 pressed
        add_entry(op_read_b, mmio_addr(kb_valid_off), 0, 1);
        add_entry(op_read_b, mmio_addr(kb_key_off), 0, 32'hb);
        add_entry(op_set_in, 4, 32'h07, 0);         // released
        add_entry(op_read_b, mmio_addr(kb_valid_off), 0, 0);
        add_entry(op_read_b, mmio_addr(kb_key_off), 0, 32'h7);
        add_entry(op_read_b, mmio_addr(8'h3c), 0, 0);
        add_entry(op_read_b, 32'hffff_0000, 0, 0);
        // LED and segment writes beside the RAM word at 0x0000ff0c
        add_entry(op_write_b, 32'h0000_ff0c, 32'h1111_2222, 0);
        add_entry(op_write_b, mmio_addr(led1_off), 32'h1234_56c3, 0);
        add_entry(op_check_out, 0, 0, 32'hc3);
        add_entry(op_write_b, mmio_addr(led2_off), 32'ha5a5_a55a, 0);
        add_entry(op_check_out, 1, 0, 32'h5a);
        add_entry(op_write_b, mmio_addr(seg1_off), 32'hdead_beef, 0);
        add_entry(op_check_out, 2, 0, 32'hdead_beef);
        add_entry(op_write_b, mmio_addr(seg2_off), 32'h0000_abcd, 0);
        add_entry(op_check_out, 3, 0, 32'h0000_abcd);
        add_entry(op_read_b, mmio_addr(led1_off), 0, 0);
        add_entry(op_read_b, 32'h0000_ff0c, 0, 32'h1111_2222);
        // text planes
        add_entry(op_write_b, 32'hffff_d020, 32'h07, 0);
        add_entry(op_write_b, 32'hffff_e020, 32'h33, 0);
        add_entry(op_write_b, 32'hffff_e020, 32'h1234_5a5a, 0);
        add_entry(op_read_disp, 32'h020, 0, 32'h075a);
        add_entry(op_write_b, 32'hffff_d020, 32'h0c, 0);
        add_entry(op_read_disp, 32'h020, 0, 32'h0c5a);
        add_entry(op_write_b, 32'hffff_e820, 32'h99, 0);    // beyond the last cell
        add_entry(op_read_disp, 32'h020, 0, 32'h0c5a);
        add_entry(op_write_b, 32'hffff_e010, 32'h41, 0);
        add_entry(op_write_b, 32'hffff_d010, 32'h1e, 0);
        add_entry(op_read_disp, 32'h010, 0, 32'h1e41);
        add_entry(op_read_b, 32'hffff_e010, 0, 0);
        // random RAM traffic over index bits 11:2
        for (int k = 0; k < rand_writes; k++) begin
            a = $random(seed);
            d = $random(seed);
            if (a[31:16] == io_region_hi || a[31:16] == exc_region_hi) begin
                a[31:16] = 16'h0000;
            end
            a[1:0] = 2'b00;
            model[a[11:2]] = d;
            rand_addr[k] = a;
            add_entry(op_write_b, a, d, 0);
        end
        for (int k = 0; k < rand_writes; k++) begin
            add_entry(op_read_b, rand_addr[k], 0, model[rand_addr[k][11:2]]);
            add_entry(op_read_a, rand_addr[k], 0, model[rand_addr[k][11:2]]);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        addra = '0;
        addrb = '0;
        write_datab = '0;
        web = 1'b0;
        sepc = '0;
        switches1 = '0;
        switches2 = '0;
        switches3 = '0;
        {bt5, bt4, bt3, bt2, bt1} = '0;
        kb_idx = '0;
        vga_addr = '0;
        errors = 0;
        checks = 0;
        seed = 32'he3d04620;
        build_table();
        step_cycles(8);
        rst_n = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            apply_entry(i);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== excp_rom.hex ====
// exception handler image, one 32-bit word per line from word 0
3c1affff
8f5bff28
00000000
277b0004
409b7000
00000000
42000018
00000000
3c08dead
3508beef
ad08ff2c
1000ffff
00000000
0bf02400
24420001
00000000

// ==== filelist.f ====
verilog/soc_bus_pkg.sv
verilog/board_io_pkg.sv
verilog/sync_ram.sv
verilog/exc_rom.sv
verilog/mmio_regs.sv
verilog/vga_text_buffer.sv
verilog/memory_system.sv
bench/memory_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the memory_system testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module memory_system_tb --Mdir obj_dir -o memory_system_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/memory_system_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$log"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// ==== verilog/board_io_pkg.sv ====
`default_nettype none

package board_io_pkg;

    // board-side widths
    localparam int swch_width     = 8;
    localparam int led_width      = 8;
    localparam int kbcode_width   = 5;    // bit 4 pressed, bits 3..0 key index
    localparam int vga_addr_width = 12;

    typedef logic [7:0] cell_t;           // one char or colour cell

    // register offsets inside 0xffffff00
    localparam logic [7:0] sw1_off       = 8'h00;
    localparam logic [7:0] sw2_off       = 8'h04;
    localparam logic [7:0] sw3_off       = 8'h08;
    localparam logic [7:0] led1_off      = 8'h0c;
    localparam logic [7:0] led2_off      = 8'h10;

    // buttons read back as 0 or 1
    localparam logic [7:0] btn_mid_off   = 8'h14;
    localparam logic [7:0] btn_up_off    = 8'h18;
    localparam logic [7:0] btn_down_off  = 8'h1c;
    localparam logic [7:0] btn_left_off  = 8'h20;
    localparam logic [7:0] btn_right_off = 8'h24;

    localparam logic [7:0] sepc_off      = 8'h28;   // saved exception pc
    localparam logic [7:0] seg1_off      = 8'h2c;
    localparam logic [7:0] seg2_off      = 8'h30;

    // keypad
    localparam logic [7:0] kb_valid_off  = 8'h34;
    localparam logic [7:0] kb_key_off    = 8'h38;

endpackage

`default_nettype wire

// ==== verilog/exc_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module exc_rom (
    input  logic                clka,
    input  logic [7:0]          addra,    // word index
    output soc_bus_pkg::data_t  douta
);

    import soc_bus_pkg::*;

    data_t rom [256];

    // words the image leaves out read as zero
    initial begin
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
        end
        $readmemh("excp_rom.hex", rom);
    end

    always_ff @(posedge clka) begin
        douta <= rom[addra];
    end

endmodule

`default_nettype wire

// ==== verilog/memory_system.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_system #(
    parameter int ram_words  = 16384,
    parameter int text_cells = 2048
) (
    input  logic                                    clka,
    input  logic                                    clkb,
    input  logic                                    rst_n,
    input  soc_bus_pkg::data_t                      addra,
    input  soc_bus_pkg::data_t                      addrb,
    input  soc_bus_pkg::data_t                      write_datab,
    input  soc_bus_pkg::data_t                      sepc,
    input  logic                                    web,
    input  logic [board_io_pkg::swch_width-1:0]     switches1,
    input  logic [board_io_pkg::swch_width-1:0]     switches2,
    input  logic [board_io_pkg::swch_width-1:0]     switches3,
    input  logic                                    bt1,
    input  logic                                    bt2,
    input  logic                                    bt3,
    input  logic                                    bt4,
    input  logic                                    bt5,
    input  logic [board_io_pkg::kbcode_width-1:0]   kb_idx,
    input  logic [board_io_pkg::vga_addr_width-1:0] vga_addr,
    output soc_bus_pkg::data_t                      dataa,
    output soc_bus_pkg::data_t                      datab,
    output soc_bus_pkg::data_t                      seg1_out,
    output soc_bus_pkg::data_t                      seg2_out,
    output logic [board_io_pkg::led_width-1:0]      led1_out,
    output logic [board_io_pkg::led_width-1:0]      led2_out,
    output board_io_pkg::cell_t                     char_out,
    output board_io_pkg::cell_t                     color_out
);

    import soc_bus_pkg::*;
    import board_io_pkg::*;

    localparam int ram_aw = $clog2(ram_words);

    logic  io_sel, exc_sel, mmio_sel, char_sel, color_sel;
    logic  io_sel_q, mmio_sel_q, exc_sel_q;
    data_t ram_douta, ram_doutb, rom_douta, mmio_rdata;

    // region decode
    assign io_sel    = addrb[31:16] == io_region_hi;
    assign exc_sel   = addra[31:16] == exc_region_hi;    // fetch side
    assign mmio_sel  = addrb[31:12] == mmio_page;
    assign char_sel  = addrb[31:12] == char_page;
    assign color_sel = addrb[31:12] == color_page;

    // selects follow the sampled address into the read cycle
    always_ff @(posedge clka) begin
        if (!rst_n) begin
            exc_sel_q <= 1'b0;
        end else begin
            exc_sel_q <= exc_sel;
        end
    end

    always_ff @(posedge clkb) begin
        if (!rst_n) begin
            io_sel_q   <= 1'b0;
            mmio_sel_q <= 1'b0;
        end else begin
            io_sel_q   <= io_sel;
            mmio_sel_q <= mmio_sel;
        end
    end

    sync_ram #(
        .word_t (data_t),
        .depth  (ram_words)
    ) main_ram (
        .clka   (clka),
        .clkb   (clkb),
        .addra  (addra[ram_aw+word_shift-1:word_shift]),
        .addrb  (addrb[ram_aw+word_shift-1:word_shift]),
        .wea    (1'b0),                 // fetch never writes
        .web    (web & ~io_sel),
        .dina   ('0),
        .dinb   (write_datab),
        .douta  (ram_douta),
        .doutb  (ram_doutb)
    );

    exc_rom excp_rom (
        .clka   (clka),
        .addra  (addra[9:2]),
        .douta  (rom_douta)
    );

    mmio_regs board_regs (
        .clkb       (clkb),
        .rst_n      (rst_n),
        .offset     (addrb[7:0]),
        .write_data (write_datab),
        .we         (web & mmio_sel),
        .switches1  (switches1),
        .switches2  (switches2),
        .switches3  (switches3),
        .bt1        (bt1),
        .bt2        (bt2),
        .bt3        (bt3),
        .bt4        (bt4),
        .bt5        (bt5),
        .kb_idx     (kb_idx),
        .sepc       (sepc),
        .rdata      (mmio_rdata),
        .led1_out   (led1_out),
        .led2_out   (led2_out),
        .seg1_out   (seg1_out),
        .seg2_out   (seg2_out)
    );

    vga_text_buffer #(
        .text_cells (text_cells)
    ) text_buf (
        .clkb       (clkb),
        .cell_addr  (addrb[vga_addr_width-1:0]),
        .write_cell (write_datab[7:0]),
        .char_we    (web & char_sel),
        .color_we   (web & color_sel),
        .vga_addr   (vga_addr),
        .char_out   (char_out),
        .color_out  (color_out)
    );

    // text pages and unmapped I/O read as zero
    assign dataa = exc_sel_q ? rom_douta : ram_douta;
    assign datab = io_sel_q ? (mmio_sel_q ? mmio_rdata : '0) : ram_doutb;

endmodule

`default_nettype wire

// ==== verilog/mmio_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmio_regs (
    input  logic                                  clkb,
    input  logic                                  rst_n,
    input  logic [7:0]                            offset,
    input  soc_bus_pkg::data_t                    write_data,
    input  logic                                  we,
    input  logic [board_io_pkg::swch_width-1:0]   switches1,
    input  logic [board_io_pkg::swch_width-1:0]   switches2,
    input  logic [board_io_pkg::swch_width-1:0]   switches3,
    input  logic                                  bt1,      // middle
    input  logic                                  bt2,      // up
    input  logic                                  bt3,      // down
    input  logic                                  bt4,      // left
    input  logic                                  bt5,      // right
    input  logic [board_io_pkg::kbcode_width-1:0] kb_idx,
    input  soc_bus_pkg::data_t                    sepc,
    output soc_bus_pkg::data_t                    rdata,
    output logic [board_io_pkg::led_width-1:0]    led1_out,
    output logic [board_io_pkg::led_width-1:0]    led2_out,
    output soc_bus_pkg::data_t                    seg1_out,
    output soc_bus_pkg::data_t                    seg2_out
);

    import soc_bus_pkg::*;
    import board_io_pkg::*;

    data_t rd_next;

    // LED and segment offsets are write only
    always_comb begin
        rd_next = '0;
        case (offset)
            sw1_off:       rd_next = data_t'(switches1);
            sw2_off:       rd_next = data_t'(switches2);
            sw3_off:       rd_next = data_t'(switches3);
            btn_mid_off:   rd_next = data_t'(bt1);
            btn_up_off:    rd_next = data_t'(bt2);
            btn_down_off:  rd_next = data_t'(bt3);
            btn_left_off:  rd_next = data_t'(bt4);
            btn_right_off: rd_next = data_t'(bt5);
            sepc_off:      rd_next = sepc;
            kb_valid_off:  rd_next = data_t'(kb_idx[kbcode_width-1]);   // key pressed
            kb_key_off:    rd_next = data_t'(kb_idx[3:0]);
            default:       rd_next = '0;
        endcase
    end

    // read word registered like the RAM output
    always_ff @(posedge clkb) begin
        if (!rst_n) begin
            rdata <= '0;
        end else begin
            rdata <= rd_next;
        end
    end

    // output registers
    always_ff @(posedge clkb) begin
        if (!rst_n) begin
            led1_out <= '0;
            led2_out <= '0;
            seg1_out <= '0;
            seg2_out <= '0;
        end else if (we) begin
            case (offset)
                led1_off: led1_out <= write_data[led_width-1:0];   // low byte only
                led2_off: led2_out <= write_data[led_width-1:0];
                seg1_off: seg1_out <= write_data;
                seg2_off: seg2_out <= write_data;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // processor bus word
    localparam int data_width = 32;

    typedef logic [data_width-1:0] data_t;

    // upper half-word region selects
    localparam logic [15:0] io_region_hi  = 16'hffff;   // memory-mapped I/O
    localparam logic [15:0] exc_region_hi = 16'h1c09;   // handler ROM on the fetch side

    // 4 KiB pages inside the I/O region
    localparam logic [19:0] mmio_page  = 20'hfffff;     // board registers
    localparam logic [19:0] char_page  = 20'hffffe;     // text characters
    localparam logic [19:0] color_page = 20'hffffd;     // text colours

    // RAM word index starts above the byte offset
    localparam int word_shift = 2;

    // cycles from sampled address to valid read data
    // every port-b source lines up on this
    localparam int read_latency = 1;

endpackage

`default_nettype wire

// ==== verilog/sync_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_ram #(
    parameter type word_t = logic [31:0],
    parameter int  depth  = 1024
) (
    input  logic                     clka,
    input  logic                     clkb,
    input  logic [$clog2(depth)-1:0] addra,
    input  logic [$clog2(depth)-1:0] addrb,
    input  logic                     wea,
    input  logic                     web,
    input  word_t                    dina,
    input  word_t                    dinb,
    output word_t                    douta,
    output word_t                    doutb
);

    word_t mem [depth];

    // port a
    always @(posedge clka) begin
        if (wea) begin
            mem[addra] <= dina;
        end
        douta <= mem[addra];    // old word on a same-port write
    end

    // port b
    always @(posedge clkb) begin
        if (web) begin
            mem[addrb] <= dinb;
        end
        doutb <= mem[addrb];
    end

endmodule

`default_nettype wire

// ==== verilog/vga_text_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_text_buffer #(
    parameter int text_cells = 2048
) (
    input  logic                                    clkb,
    input  logic [board_io_pkg::vga_addr_width-1:0] cell_addr,
    input  board_io_pkg::cell_t                     write_cell,
    input  logic                                    char_we,
    input  logic                                    color_we,
    input  logic [board_io_pkg::vga_addr_width-1:0] vga_addr,
    output board_io_pkg::cell_t                     char_out,
    output board_io_pkg::cell_t                     color_out
);

    import board_io_pkg::*;

    localparam int cell_aw = $clog2(text_cells);

    logic in_range;

    // drop bus writes past the last cell
    assign in_range = int'(cell_addr) < text_cells;

    // port a is the display side, port b the bus side
    sync_ram #(
        .word_t (cell_t),
        .depth  (text_cells)
    ) char_plane (
        .clka   (clkb),
        .clkb   (clkb),
        .addra  (vga_addr[cell_aw-1:0]),
        .addrb  (cell_addr[cell_aw-1:0]),
        .wea    (1'b0),
        .web    (char_we & in_range),
        .dina   ('0),
        .dinb   (write_cell),
        .douta  (char_out),
        .doutb  ()
    );

    sync_ram #(
        .word_t (cell_t),
        .depth  (text_cells)
    ) color_plane (
        .clka   (clkb),
        .clkb   (clkb),
        .addra  (vga_addr[cell_aw-1:0]),
        .addrb  (cell_addr[cell_aw-1:0]),
        .wea    (1'b0),
        .web    (color_we & in_range),
        .dina   ('0),
        .dinb   (write_cell),
        .douta  (color_out),
        .doutb  ()
    );

endmodule

`default_nettype wire
